/* design/median_defines.svh */
`ifndef MEDIAN_DEFINES_SVH
`define MEDIAN_DEFINES_SVH

// Window edge in pixels, 11 x 11 words per window
`define MEDIAN_WIN_DIM 11

// Pixel word is the candidate flag on top of the sample
`define MEDIAN_PIXEL_W 10
`define MEDIAN_SAMPLE_W (`MEDIAN_PIXEL_W - 1)

// Rank of the median among 121 samples
`define MEDIAN_RANK 61

// Rank sum and plane count share this width
`define MEDIAN_SUM_W 7

`endif

/* design/pixel_pkg.sv */
`default_nettype none

`include "median_defines.svh"

package pixel_pkg;

    // Flag in the top bit, sample below it
    typedef struct packed {
        logic                        cand;
        logic [`MEDIAN_SAMPLE_W-1:0] sample;
    } pixel_t;

    // Word value after reset
    localparam pixel_t PIXEL_INIT = '{cand: 1'b1, sample: '0};

    // Examined plane bit of one sample
    function automatic logic plane_set(input pixel_t pix, input int unsigned plane);
        plane_set = pix.sample[plane];
    endfunction

endpackage

`default_nettype wire

/* design/window_pkg.sv */
`default_nettype none

`include "median_defines.svh"

package window_pkg;

    // Element 0 in the low bits
    typedef pixel_pkg::pixel_t [`MEDIAN_WIN_DIM-1:0] row_t;

    typedef row_t [`MEDIAN_WIN_DIM-1:0] window_t;

    // Candidates with the plane bit set, 0 to 121
    typedef logic [`MEDIAN_SUM_W-1:0] count_t;

    // Samples ranked below the current search value
    typedef logic [`MEDIAN_SUM_W-1:0] rank_sum_t;

    // Decision handed to the window update
    typedef struct packed {
        logic      keep_low;
        rank_sum_t next_sum;
    } rank_step_t;

endpackage

`default_nettype wire

/* design/window_count.sv */
`timescale 1ns/1ns
`default_nettype none

`include "median_defines.svh"

module window_count #(
    parameter int PLANE_BIT = 7
) (
    input  wire window_pkg::window_t i_window,
    output window_pkg::count_t       o_count
);

    logic [`MEDIAN_WIN_DIM-1:0] hits [`MEDIAN_WIN_DIM];
    window_pkg::count_t         row_count [`MEDIAN_WIN_DIM];

    // Only live candidates take part in the count
    always_comb begin
        for (int r = 0; r < `MEDIAN_WIN_DIM; r++) begin
            for (int c = 0; c < `MEDIAN_WIN_DIM; c++) begin
                hits[r][c] = i_window[r][c].cand &
                             pixel_pkg::plane_set(i_window[r][c], PLANE_BIT);
            end
        end
    end

    // Per-row adder chain
    always_comb begin
        for (int r = 0; r < `MEDIAN_WIN_DIM; r++) begin
            row_count[r] = '0;
            for (int c = 0; c < `MEDIAN_WIN_DIM; c++) begin
                row_count[r] = row_count[r] + window_pkg::count_t'(hits[r][c]);
            end
        end
    end

    // Sum of rows
    always_comb begin
        o_count = '0;
        for (int r = 0; r < `MEDIAN_WIN_DIM; r++) begin
            o_count = o_count + row_count[r];
        end
    end

endmodule

`default_nettype wire

/* design/rank_decide.sv */
`timescale 1ns/1ns
`default_nettype none

`include "median_defines.svh"

module rank_decide (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   i_clken,
    input  wire window_pkg::count_t     i_count,
    input  wire window_pkg::rank_sum_t  i_pre_sum,
    output window_pkg::rank_step_t      o_step,
    output window_pkg::rank_sum_t       o_post_sum,
    output logic                        o_valid
);

    logic [`MEDIAN_SUM_W:0] total;
    logic                   keep_low;
    window_pkg::rank_sum_t  next_sum;

    // One extra bit holds pre-sum plus a full window
    assign total = {1'b0, i_count} + {1'b0, i_pre_sum};

    // Median still above this plane value
    assign keep_low = (total < `MEDIAN_RANK);

    // Below the rank the total always fits the sum width
    assign next_sum = keep_low ? total[`MEDIAN_SUM_W-1:0] : i_pre_sum;

    always_comb begin
        o_step          = '0;
        o_step.keep_low = keep_low;
        o_step.next_sum = next_sum;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_post_sum <= '0;
            o_valid    <= 1'b0;
        end else if (i_clken) begin
            o_post_sum <= next_sum;
            // Sticky once the first item is through
            o_valid    <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/candidate_update.sv */
`timescale 1ns/1ns
`default_nettype none

`include "median_defines.svh"

module candidate_update #(
    parameter int PLANE_BIT = 7
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                i_clken,
    input  wire window_pkg::window_t i_window,
    input  wire logic                i_keep_low,
    output window_pkg::window_t      o_window
);

    window_pkg::window_t next_window;

    // Lower half keeps bit-clear words, upper half keeps bit-set words
    always_comb begin
        for (int r = 0; r < `MEDIAN_WIN_DIM; r++) begin
            for (int c = 0; c < `MEDIAN_WIN_DIM; c++) begin
                next_window[r][c].cand =
                    i_window[r][c].cand &
                    (pixel_pkg::plane_set(i_window[r][c], PLANE_BIT) ^ i_keep_low);
                next_window[r][c].sample = i_window[r][c].sample;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int r = 0; r < `MEDIAN_WIN_DIM; r++) begin
                for (int c = 0; c < `MEDIAN_WIN_DIM; c++) begin
                    o_window[r][c] <= pixel_pkg::PIXEL_INIT;
                end
            end
        end else if (i_clken) begin
            o_window <= next_window;
        end
    end

endmodule

`default_nettype wire

/* design/bit_plane_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module bit_plane_stage #(
    parameter int PLANE_BIT = 7
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   i_clken,
    input  wire window_pkg::window_t    i_window,
    input  wire window_pkg::rank_sum_t  i_pre_sum,
    output window_pkg::window_t         o_window,
    output window_pkg::rank_sum_t       o_post_sum,
    output logic                        o_valid
);

    window_pkg::count_t     count;
    window_pkg::rank_step_t step;

    // Decode
    window_count #(
        .PLANE_BIT (PLANE_BIT)
    ) u_window_count (
        .i_window (i_window),
        .o_count  (count)
    );

    // Execute, sum and valid registered here
    rank_decide u_rank_decide (
        .clk        (clk),
        .rst        (rst),
        .i_clken    (i_clken),
        .i_count    (count),
        .i_pre_sum  (i_pre_sum),
        .o_step     (step),
        .o_post_sum (o_post_sum),
        .o_valid    (o_valid)
    );

    // Result, window registered on the same edge
    candidate_update #(
        .PLANE_BIT (PLANE_BIT)
    ) u_candidate_update (
        .clk        (clk),
        .rst        (rst),
        .i_clken    (i_clken),
        .i_window   (i_window),
        .i_keep_low (step.keep_low),
        .o_window   (o_window)
    );

endmodule

`default_nettype wire

/* dv/tb_bit_plane_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "median_defines.svh"

module tb_bit_plane_stage;

    localparam int PLANE     = 7;
    localparam int TIMEOUT   = 20;
    localparam int NUM_TESTS = 14;

    // How a test window is filled
    typedef enum logic [2:0] {
        KIND_RANDOM,
        KIND_ALL,
        KIND_NONE,
        KIND_SET,
        KIND_CLEAR
    } kind_t;

    // One row of the stimulus table, density in percent
    typedef struct packed {
        kind_t                 kind;
        logic [6:0]            density;
        window_pkg::rank_sum_t pre_sum;
        logic                  clken;
    } entry_t;

    localparam entry_t TESTS [NUM_TESTS] = '{
        '{KIND_RANDOM, 7'd50,  7'd10, 1'b0},
        '{KIND_RANDOM, 7'd20,  7'd0,  1'b1},
        '{KIND_SET,    7'd100, 7'd0,  1'b1},
        '{KIND_RANDOM, 7'd70,  7'd40, 1'b0},
        '{KIND_CLEAR,  7'd100, 7'd60, 1'b1},
        '{KIND_SET,    7'd100, 7'd60, 1'b1},
        '{KIND_NONE,   7'd0,   7'd20, 1'b1},
        '{KIND_CLEAR,  7'd100, 7'd61, 1'b1},
        '{KIND_SET,    7'd100, 7'd5,  1'b0},
        '{KIND_RANDOM, 7'd50,  7'd25, 1'b1},
        '{KIND_ALL,    7'd100, 7'd0,  1'b1},
        '{KIND_RANDOM, 7'd90,  7'd5,  1'b1},
        '{KIND_RANDOM, 7'd10,  7'd50, 1'b1},
        '{KIND_CLEAR,  7'd30,  7'd0,  1'b0}
    };

    string names [NUM_TESTS] = '{
        "hold_after_reset",
        "lower_sparse",
        "upper_all_set",
        "hold_random",
        "lower_all_clear",
        "upper_pre60_full",
        "no_candidates",
        "rank_exact",
        "hold_plane_set",
        "random_mid",
        "all_cand_random",
        "random_dense",
        "random_light",
        "hold_final"
    };

    logic                  clk;
    logic                  rst;
    logic                  i_clken;
    window_pkg::window_t   i_window;
    window_pkg::rank_sum_t i_pre_sum;
    window_pkg::window_t   o_window;
    window_pkg::rank_sum_t o_post_sum;
    logic                  o_valid;

    // Expected outputs
    window_pkg::window_t   exp_window;
    window_pkg::rank_sum_t exp_sum;
    logic                  exp_valid;

    int   pass_count;
    int   fail_count;
    logic timed_out;

    bit_plane_stage #(
        .PLANE_BIT (PLANE)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .i_clken    (i_clken),
        .i_window   (i_window),
        .i_pre_sum  (i_pre_sum),
        .o_window   (o_window),
        .o_post_sum (o_post_sum),
        .o_valid    (o_valid)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic make_window(input entry_t e, output window_pkg::window_t w);
        pixel_pkg::pixel_t pix;
        for (int r = 0; r < `MEDIAN_WIN_DIM; r++) begin
            for (int c = 0; c < `MEDIAN_WIN_DIM; c++) begin
                pix.sample = 9'($urandom);
                pix.cand   = (($urandom % 100) < e.density);
                case (e.kind)
                    KIND_ALL:   pix.cand = 1'b1;
                    KIND_NONE:  pix.cand = 1'b0;
                    KIND_SET:   pix.sample[PLANE] = 1'b1;
                    KIND_CLEAR: pix.sample[PLANE] = 1'b0;
                    default:    ;
                endcase
                w[r][c] = pix;
            end
        end
    endtask

    // Reference for one enabled edge
    task automatic run_model(input window_pkg::window_t w,
                             input window_pkg::rank_sum_t pre,
                             input logic en);
        int   hits;
        int   total;
        logic low;
        logic bit_set;
        if (en) begin
            hits = 0;
            for (int r = 0; r < `MEDIAN_WIN_DIM; r++) begin
                for (int c = 0; c < `MEDIAN_WIN_DIM; c++) begin
                    if (w[r][c].cand && w[r][c].sample[PLANE]) begin
                        hits++;
                    end
                end
            end
            total   = hits + pre;
            low     = (total < `MEDIAN_RANK);
            exp_sum = low ? window_pkg::rank_sum_t'(total) : pre;
            for (int r = 0; r < `MEDIAN_WIN_DIM; r++) begin
                for (int c = 0; c < `MEDIAN_WIN_DIM; c++) begin
                    bit_set = w[r][c].sample[PLANE];
                    exp_window[r][c].sample = w[r][c].sample;
                    if (low) begin
                        exp_window[r][c].cand = w[r][c].cand && !bit_set;
                    end else begin
                        exp_window[r][c].cand = w[r][c].cand && bit_set;
                    end
                end
            end
            exp_valid = 1'b1;
        end
    endtask

    task automatic wait_result(input logic en, output logic ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < TIMEOUT) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
            // An enabled item must raise valid one edge later
            if (!en || o_valid) begin
                ok = 1'b1;
            end
        end
        if (!ok) begin
            $display("Timeout: o_valid stayed low for %0d cycles after an enabled item",
                     TIMEOUT);
        end
    endtask

    task automatic check_outputs(input string name);
        int   errors;
        logic found;
        errors = 0;
        found  = 1'b0;
        if (o_valid !== exp_valid) begin
            $display("Error %s: o_valid expected %0b actual %0b", name, exp_valid, o_valid);
            errors++;
        end
        if (o_post_sum !== exp_sum) begin
            $display("Error %s: o_post_sum expected %0d actual %0d", name, exp_sum,
                     o_post_sum);
            errors++;
        end
        for (int r = 0; r < `MEDIAN_WIN_DIM; r++) begin
            for (int c = 0; c < `MEDIAN_WIN_DIM; c++) begin
                if (!found && o_window[r][c] !== exp_window[r][c]) begin
                    $display("Error %s: o_window[%0d][%0d] expected %03h actual %03h",
                             name, r, c, exp_window[r][c], o_window[r][c]);
                    found = 1'b1;
                    errors++;
                end
            end
        end
        if (errors == 0) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    initial begin
        entry_t              e;
        window_pkg::window_t w;
        logic                ok;
        rst        <= 1'b0;
        i_clken    <= 1'b0;
        i_window   <= '0;
        i_pre_sum  <= '0;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        void'($urandom(32'h6f93));

        // Reset state is flag 1, sample 0 in every word
        for (int r = 0; r < `MEDIAN_WIN_DIM; r++) begin
            for (int c = 0; c < `MEDIAN_WIN_DIM; c++) begin
                exp_window[r][c].cand   = 1'b1;
                exp_window[r][c].sample = '0;
            end
        end
        exp_sum   = '0;
        exp_valid = 1'b0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_outputs("reset");
        @(posedge clk);
        rst <= 1'b1;

        for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
            e = TESTS[i];
            make_window(e, w);
            @(posedge clk);
            i_window  <= w;
            i_pre_sum <= e.pre_sum;
            i_clken   <= e.clken;
            run_model(w, e.pre_sum, e.clken);
            wait_result(e.clken, ok);
            if (!ok) begin
                timed_out = 1'b1;
            end else begin
                check_outputs(names[i]);
            end
        end

        $display("%0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/pixel_pkg.sv
design/window_pkg.sv
design/window_count.sv
design/rank_decide.sv
design/candidate_update.sv
design/bit_plane_stage.sv
dv/tb_bit_plane_stage.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_bit_plane_stage
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) design/median_defines.svh

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
